// ==== flist.f ====
logic/bomberman_pkg.sv
logic/tile_check_if.sv
logic/tile_decode.sv
logic/player_stats.sv
logic/player_motion.sv
logic/bomberman_core.sv
tb/bomberman_core_props.sv
tb/bomberman_core_tb.sv

// ==== tb/bomberman_core_tb.sv ====
// self-checking testbench for bomberman_core with a reference model of both players.
`timescale 1ns/1ns

module bomberman_core_tb;

	localparam int INV_CYCLES = 20;

	typedef struct packed {
		logic [1:0] lives;
		logic [1:0] bombs;
		logic [1:0] radius;
		logic [1:0] potency;
		logic [3:0] speed;
		logic [7:0] inv;
		logic [3:0] pass;
		logic [8:0] x;
		logic [8:0] y;
	} player_t;

	logic clock = 1'b0;
	logic reset, game_reset, check_p1, check_p2, has_explosion, refresh;
	logic [1:0] corner_id;
	bomberman_pkg::tile_id_t map_tile_id;
	logic p1_xdir, p1_xmov, p1_ydir, p1_ymov, p2_xdir, p2_xmov, p2_ydir, p2_ymov;
	bomberman_pkg::coord_t probe_x, probe_y, p1_x, p1_y, p2_x, p2_y;
	logic destroy_tile, p1_invincible, p2_invincible;
	bomberman_pkg::lives_t p1_lives, p2_lives;
	logic [5:0] p1_stats, p2_stats;
	bomberman_pkg::speed_t p1_speed, p2_speed;
	player_t m1, m2;
	logic m_destroy;
	int errors = 0;
	int mark = 0;
	int tests = 0;

	bomberman_core #(.INV_CYCLES(INV_CYCLES)) bomberman_core_inst (.*);

	always #2 clock = ~clock;

	function automatic player_t start_player(logic [8:0] x0);
		player_t p;
		p = '0;
		p.lives = bomberman_pkg::START_LIVES;
		p.speed = bomberman_pkg::START_SPEED;
		p.x = x0;
		p.y = bomberman_pkg::START_Y;
		return p;
	endfunction

	// next state of one player from the game rules.
	// mv packs xdir, xmov, ydir and ymov.
	function automatic player_t next_player(player_t p, logic chk, logic [1:0] corner,
		logic [3:0] tile, logic hit, logic refresh_in, logic [3:0] mv);
		player_t n;
		logic damage;
		n = p;
		damage = chk && hit && p.inv == 0;
		if (damage)
		begin
			n.inv = INV_CYCLES;
			if (p.lives != 0)
				n.lives = p.lives - 1;
		end
		else if (p.inv != 0)
			n.inv = p.inv - 1;
		if (chk)
		begin
			n.pass[corner] = tile == 0 || (tile >= 3 && tile <= 8) || tile >= 12;
			if (tile == 3 && p.bombs < 2) n.bombs = p.bombs + 1;
			if (tile == 4 && p.radius < 2) n.radius = p.radius + 1;
			if (tile == 5 && p.potency < 2) n.potency = p.potency + 1;
			if (tile == 8 && p.speed < 8) n.speed = p.speed + 1;
			if (tile == 7 && !damage && p.lives < 3) n.lives = p.lives + 1;
		end
		if (refresh_in && mv[2] && (mv[3] ? p.pass[1] && p.pass[3] : p.pass[0] && p.pass[2]))
		begin
			if (mv[3] && int'(p.x) + int'(p.speed) <= 232) n.x = p.x + p.speed;
			if (!mv[3] && int'(p.x) - int'(p.speed) >= 72) n.x = p.x - p.speed;
		end
		if (refresh_in && mv[0] && (mv[1] ? p.pass[2] && p.pass[3] : p.pass[0] && p.pass[1]))
		begin
			if (mv[1] && int'(p.y) + int'(p.speed) <= 192) n.y = p.y + p.speed;
			if (!mv[1] && int'(p.y) - int'(p.speed) >= 32) n.y = p.y - p.speed;
		end
		return n;
	endfunction

	always @(posedge clock or posedge reset)
	begin
		if (reset || game_reset)
		begin
			m1 <= start_player(9'd72);
			m2 <= start_player(9'd232);
			m_destroy <= 1'b0;
		end
		else
		begin
			m1 <= next_player(m1, check_p1, corner_id, map_tile_id, has_explosion, refresh,
				{p1_xdir, p1_xmov, p1_ydir, p1_ymov});
			m2 <= next_player(m2, check_p2 && !check_p1, corner_id, map_tile_id, has_explosion,
				refresh, {p2_xdir, p2_xmov, p2_ydir, p2_ymov});
			m_destroy <= (check_p1 || check_p2) && map_tile_id >= 3 && map_tile_id <= 8;
		end
	end

	task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
			errors++;
		end
	endtask

	task automatic compare_player(string tag, logic [1:0] lives, logic [5:0] stats,
		logic [3:0] speed, logic [8:0] x, logic [8:0] y, logic inv, player_t m);
		compare_value({tag, "_lives"}, lives, m.lives);
		compare_value({tag, "_stats"}, stats, {m.bombs, m.radius, m.potency});
		compare_value({tag, "_speed"}, speed, m.speed);
		compare_value({tag, "_x"}, x, m.x);
		compare_value({tag, "_y"}, y, m.y);
		compare_value({tag, "_invincible"}, inv, m.inv != 0);
	endtask

	// outputs are settled by the falling edge.
	always @(negedge clock)
	begin
		if (!reset)
		begin
			compare_player("p1", p1_lives, p1_stats, p1_speed, p1_x, p1_y, p1_invincible, m1);
			compare_player("p2", p2_lives, p2_stats, p2_speed, p2_x, p2_y, p2_invincible, m2);
			compare_value("destroy_tile", destroy_tile, m_destroy);
			if (check_p1 || check_p2)
			begin
				compare_value("probe_x", probe_x,
					9'((check_p1 ? m1.x : m2.x) + (corner_id[0] ? 15 : 0)));
				compare_value("probe_y", probe_y,
					9'((check_p1 ? m1.y : m2.y) + (corner_id[1] ? 15 : 0)));
			end
		end
	end

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	// drives one check cycle and drops the strobes after it.
	task automatic check_tile(logic c1, logic c2, logic [1:0] corner, logic [3:0] tile,
		logic hit);
		check_p1 = c1;
		check_p2 = c2;
		corner_id = corner;
		map_tile_id = bomberman_pkg::tile_id_t'(tile);
		has_explosion = hit;
		next_cycle();
		check_p1 = 1'b0;
		check_p2 = 1'b0;
		has_explosion = 1'b0;
	endtask

	task automatic pulse_refresh();
		refresh = 1'b1;
		next_cycle();
		refresh = 1'b0;
		next_cycle();
	endtask

	task automatic expect_start_values();
		compare_player("p1", p1_lives, p1_stats, p1_speed, p1_x, p1_y, p1_invincible,
			start_player(9'd72));
		compare_player("p2", p2_lives, p2_stats, p2_speed, p2_x, p2_y, p2_invincible,
			start_player(9'd232));
		compare_value("destroy_tile", destroy_tile, 0);
	endtask

	task automatic finish_test(string name);
		$display("test %s: %0d errors", name, errors - mark);
		mark = errors;
		tests++;
	endtask

	initial
	begin
		int high_count;
		logic [8:0] x_before;
		void'($urandom(32'h10aa1631));
		{reset, game_reset, check_p1, check_p2, has_explosion, refresh} = 6'b100000;
		corner_id = 2'd0;
		map_tile_id = bomberman_pkg::tile_empty;
		{p1_xdir, p1_xmov, p1_ydir, p1_ymov, p2_xdir, p2_xmov, p2_ydir, p2_ymov} = '0;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		next_cycle();
		expect_start_values();
		finish_test("reset_values");

		for (int i = 0; i < 120; i++)
		begin
			case ($urandom % 3)
				0: check_tile(1, 0, $urandom % 4, 3 + $urandom % 6, 0);
				1: check_tile(0, 1, $urandom % 4, 3 + $urandom % 6, 0);
				default: check_tile(1, 1, $urandom % 4, 3 + $urandom % 6, 0);
			endcase
			if ($urandom % 2)
				next_cycle();
		end
		finish_test("pickups");

		check_tile(1, 0, 0, 0, 1);
		high_count = 0;
		for (int n = 0; n < INV_CYCLES + 10 && p1_invincible; n++)
		begin
			high_count++;
			check_p1 = high_count == 5;	// second hit inside the window.
			has_explosion = high_count == 5;
			next_cycle();
			{check_p1, has_explosion} = 2'b00;
		end
		if (p1_invincible)
		begin
			$display("invincibility window did not end within the timeout");
			errors++;
		end
		compare_value("p1_invincible_cycles", high_count, INV_CYCLES);
		compare_value("p1_lives", p1_lives, bomberman_pkg::START_LIVES - 1);
		check_tile(1, 0, 0, 0, 1);	// a hit once the window is over.
		check_tile(1, 0, 0, 7, 0);	// extra life while invincible.
		compare_value("p1_lives", p1_lives, bomberman_pkg::START_LIVES - 1);
		finish_test("hit_invincibility");

		for (int c = 0; c < 4; c++)
		begin
			check_tile(1, 0, c, 0, 0);
			check_tile(0, 1, c, 0, 0);
		end
		{p1_xdir, p1_xmov, p1_ydir, p1_ymov, p2_xdir, p2_xmov, p2_ydir, p2_ymov} = 8'b11110101;
		repeat (50) pulse_refresh();
		if (int'(p1_x) + int'(p1_speed) <= 232)
		begin
			$display("p1 did not reach the right arena edge");
			errors++;
		end
		{p1_xdir, p1_ydir, p2_xdir, p2_ydir} = 4'b0011;
		repeat (50) pulse_refresh();
		p1_xdir = 1'b1;
		check_tile(1, 0, 1, 1, 0);	// wall on the upper right corner.
		x_before = p1_x;
		pulse_refresh();
		compare_value("p1_x", p1_x, x_before);
		{p1_xmov, p1_ymov, p2_xmov, p2_ymov} = 4'b0000;
		finish_test("movement");

		for (int i = 0; i < 20; i++)
			check_tile($urandom % 2, $urandom % 2, $urandom % 4, 0, 0);
		check_tile(1, 1, 3, 0, 0);
		finish_test("probe");

		game_reset = 1'b1;
		next_cycle();
		game_reset = 1'b0;
		expect_start_values();
		finish_test("game_reset");

		errors = errors + bomberman_core_inst.props_inst.fails;
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== tb/bomberman_core_props.sv ====
// concurrent assertions bound into bomberman_core to watch reset, tile removal, lives and bounds.
`timescale 1ns/1ns

module bomberman_core_props (
	input logic clock,
	input logic reset,
	input logic game_reset,
	input logic check_p1,
	input logic check_p2,
	input logic destroy_tile,
	input bomberman_pkg::lives_t p1_lives,
	input bomberman_pkg::lives_t p2_lives,
	input bomberman_pkg::coord_t p1_x,
	input bomberman_pkg::coord_t p1_y,
	input bomberman_pkg::coord_t p2_x,
	input bomberman_pkg::coord_t p2_y,
	input logic p1_invincible,
	input logic p2_invincible
);

	int fails = 0;	// count of failed assertions.

	assert property (@(posedge clock) $fell(reset) |-> !p1_invincible && !p2_invincible)
	else
	begin
		$error("invincible flag set right after reset");
		fails++;
	end

	// a removal strobe always follows a check.
	assert property (@(posedge clock) disable iff (reset)
		destroy_tile |-> $past(check_p1 || check_p2))
	else
	begin
		$error("destroy_tile without a check in the cycle before");
		fails++;
	end

	// lives step by at most one per clock and never wrap past zero or the limit.
	assert property (@(posedge clock) disable iff (reset)
		!$past(game_reset) |->
		int'(p1_lives) <= int'($past(p1_lives)) + 1 &&
		int'(p1_lives) + 1 >= int'($past(p1_lives)) &&
		int'(p2_lives) <= int'($past(p2_lives)) + 1 &&
		int'(p2_lives) + 1 >= int'($past(p2_lives)))
	else
	begin
		$error("lives changed by more than one in a clock");
		fails++;
	end

	assert property (@(posedge clock) disable iff (reset)
		p1_x >= bomberman_pkg::X_MIN && p1_x <= bomberman_pkg::X_MAX &&
		p2_x >= bomberman_pkg::X_MIN && p2_x <= bomberman_pkg::X_MAX &&
		p1_y >= bomberman_pkg::Y_MIN && p1_y <= bomberman_pkg::Y_MAX &&
		p2_y >= bomberman_pkg::Y_MIN && p2_y <= bomberman_pkg::Y_MAX)
	else
	begin
		$error("player coordinate outside the arena");
		fails++;
	end

endmodule

bind bomberman_core bomberman_core_props props_inst (.*);

// ==== logic/bomberman_core.sv ====
// top level of the gameplay datapath: one tile decoder feeding a stats and motion pair per player.
`timescale 1ns/1ns

module bomberman_core #(
	parameter int INV_CYCLES = 20
) (
	input logic clock,
	input logic reset,
	input logic game_reset,
	input logic check_p1,
	input logic check_p2,
	input logic [1:0] corner_id,
	input bomberman_pkg::tile_id_t map_tile_id,
	input logic has_explosion,
	input logic refresh,
	input logic p1_xdir,
	input logic p1_xmov,
	input logic p1_ydir,
	input logic p1_ymov,
	input logic p2_xdir,
	input logic p2_xmov,
	input logic p2_ydir,
	input logic p2_ymov,
	output bomberman_pkg::coord_t probe_x,
	output bomberman_pkg::coord_t probe_y,
	output logic destroy_tile,
	output bomberman_pkg::lives_t p1_lives,
	output bomberman_pkg::lives_t p2_lives,
	output logic [5:0] p1_stats,
	output logic [5:0] p2_stats,
	output bomberman_pkg::speed_t p1_speed,
	output bomberman_pkg::speed_t p2_speed,
	output bomberman_pkg::coord_t p1_x,
	output bomberman_pkg::coord_t p1_y,
	output bomberman_pkg::coord_t p2_x,
	output bomberman_pkg::coord_t p2_y,
	output logic p1_invincible,
	output logic p2_invincible
);

	tile_check_if p1_chk ();
	tile_check_if p2_chk ();

	tile_decode decode_inst (
		.clock(clock),
		.reset(reset),
		.game_reset(game_reset),
		.check_p1(check_p1),
		.check_p2(check_p2),
		.corner_id(corner_id),
		.map_tile_id(map_tile_id),
		.has_explosion(has_explosion),
		.p1_x(p1_x),
		.p1_y(p1_y),
		.p2_x(p2_x),
		.p2_y(p2_y),
		.probe_x(probe_x),
		.probe_y(probe_y),
		.destroy_tile(destroy_tile),
		.p1_chk(p1_chk.decode),
		.p2_chk(p2_chk.decode)
	);

	player_stats #(.INV_CYCLES(INV_CYCLES)) p1_stats_inst (
		.clock(clock),
		.reset(reset),
		.game_reset(game_reset),
		.chk(p1_chk.player),
		.lives(p1_lives),
		.stats(p1_stats),
		.speed(p1_speed),
		.invincible(p1_invincible)
	);

	player_stats #(.INV_CYCLES(INV_CYCLES)) p2_stats_inst (
		.clock(clock),
		.reset(reset),
		.game_reset(game_reset),
		.chk(p2_chk.player),
		.lives(p2_lives),
		.stats(p2_stats),
		.speed(p2_speed),
		.invincible(p2_invincible)
	);

	player_motion #(.START_X(bomberman_pkg::P1_START_X)) p1_motion_inst (
		.clock(clock),
		.reset(reset),
		.game_reset(game_reset),
		.refresh(refresh),
		.chk(p1_chk.player),
		.speed(p1_speed),
		.xdir(p1_xdir),
		.xmov(p1_xmov),
		.ydir(p1_ydir),
		.ymov(p1_ymov),
		.x(p1_x),
		.y(p1_y)
	);

	player_motion #(.START_X(bomberman_pkg::P2_START_X)) p2_motion_inst (
		.clock(clock),
		.reset(reset),
		.game_reset(game_reset),
		.refresh(refresh),
		.chk(p2_chk.player),
		.speed(p2_speed),
		.xdir(p2_xdir),
		.xmov(p2_xmov),
		.ydir(p2_ydir),
		.ymov(p2_ymov),
		.x(p2_x),
		.y(p2_y)
	);

endmodule

// ==== logic/player_motion.sv ====
// per-player corner passability and the x/y coordinate counters stepped on each refresh pulse.
`timescale 1ns/1ns

module player_motion #(
	parameter bomberman_pkg::coord_t START_X = bomberman_pkg::P1_START_X
) (
	input logic clock,
	input logic reset,
	input logic game_reset,
	input logic refresh,
	tile_check_if.player chk,
	input bomberman_pkg::speed_t speed,
	input logic xdir,
	input logic xmov,
	input logic ydir,
	input logic ymov,
	output bomberman_pkg::coord_t x,
	output bomberman_pkg::coord_t y
);

	logic [3:0] passable;	// one bit per sprite corner.
	logic x_en;
	logic y_en;

	// steps toward hi when dir is set, holds if the step would leave the arena.
	function automatic bomberman_pkg::coord_t step_coord(
		input bomberman_pkg::coord_t cur,
		input logic dir,
		input bomberman_pkg::speed_t step,
		input bomberman_pkg::coord_t lo,
		input bomberman_pkg::coord_t hi
	);
		bomberman_pkg::coord_t delta;
		bomberman_pkg::coord_t result;
		delta = {5'd0, step};
		result = cur;
		if (dir)
		begin
			if (cur <= hi - delta)
				result = cur + delta;
		end
		else if (cur >= lo + delta)
		begin
			result = cur - delta;
		end
		return result;
	endfunction

	// right needs corners 1 and 3, left 0 and 2.
	assign x_en = xmov & (xdir ? (passable[1] & passable[3]) : (passable[0] & passable[2]));
	// down needs corners 2 and 3, up 0 and 1.
	assign y_en = ymov & (ydir ? (passable[2] & passable[3]) : (passable[0] & passable[1]));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			passable <= '0;
		else if (game_reset)
			passable <= '0;
		else if (chk.check)
			passable[chk.corner] <= chk.passable;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			x <= START_X;
			y <= bomberman_pkg::START_Y;
		end
		else if (game_reset)
		begin
			x <= START_X;
			y <= bomberman_pkg::START_Y;
		end
		else if (refresh)
		begin
			if (x_en)
				x <= step_coord(x, xdir, speed, bomberman_pkg::X_MIN, bomberman_pkg::X_MAX);
			if (y_en)
				y <= step_coord(y, ydir, speed, bomberman_pkg::Y_MIN, bomberman_pkg::Y_MAX);
		end
	end

endmodule

// ==== logic/player_stats.sv ====
// per-player lives, speed and power stats, with damage and the invincibility window.
`timescale 1ns/1ns

module player_stats #(
	parameter int INV_CYCLES = 20
) (
	input logic clock,
	input logic reset,
	input logic game_reset,
	tile_check_if.player chk,
	output bomberman_pkg::lives_t lives,
	output logic [5:0] stats,
	output bomberman_pkg::speed_t speed,
	output logic invincible
);

	localparam int INV_W = $clog2(INV_CYCLES + 1);

	logic [INV_W-1:0] inv_count;
	bomberman_pkg::stat_t bombs;
	bomberman_pkg::stat_t radius;
	bomberman_pkg::stat_t potency;
	logic damage;
	logic life_pick;

	assign damage = chk.check & chk.hit & ~invincible;
	assign life_pick = chk.check & (chk.pickup == bomberman_pkg::pick_life);
	assign invincible = (inv_count != '0);
	assign stats = {bombs, radius, potency};	// bombs, radius, potency.

	// counts down from INV_CYCLES, so the flag is high that many clocks.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			inv_count <= '0;
		else if (game_reset)
			inv_count <= '0;
		else if (damage)
			inv_count <= INV_W'(INV_CYCLES);
		else if (invincible)
			inv_count <= inv_count - 1'b1;
	end

	// a hit outranks an extra life picked up in the same check.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			lives <= bomberman_pkg::START_LIVES;
		else if (game_reset)
			lives <= bomberman_pkg::START_LIVES;
		else if (damage)
		begin
			if (lives != '0)
				lives <= lives - 1'b1;	// saturates at zero.
		end
		else if (life_pick && lives < bomberman_pkg::LIFE_LIMIT)
			lives <= lives + 1'b1;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			bombs <= '0;
			radius <= '0;
			potency <= '0;
			speed <= bomberman_pkg::START_SPEED;
		end
		else if (game_reset)
		begin
			bombs <= '0;
			radius <= '0;
			potency <= '0;
			speed <= bomberman_pkg::START_SPEED;
		end
		else if (chk.check)
		begin
			case (chk.pickup)
				bomberman_pkg::pick_bomb:
					if (bombs < bomberman_pkg::STAT_LIMIT)
						bombs <= bombs + 1'b1;
				bomberman_pkg::pick_radius:
					if (radius < bomberman_pkg::STAT_LIMIT)
						radius <= radius + 1'b1;
				bomberman_pkg::pick_potency:
					if (potency < bomberman_pkg::STAT_LIMIT)
						potency <= potency + 1'b1;
				bomberman_pkg::pick_speed:
					if (speed < bomberman_pkg::SPEED_LIMIT)
						speed <= speed + 1'b1;
				default:
					;	// lives handled above.
			endcase
		end
	end

endmodule

// ==== logic/tile_decode.sv ====
// forms the probe coordinate for a corner check and classifies the tile the stage memory returns.
`timescale 1ns/1ns

module tile_decode (
	input logic clock,
	input logic reset,
	input logic game_reset,
	input logic check_p1,
	input logic check_p2,
	input logic [1:0] corner_id,
	input bomberman_pkg::tile_id_t map_tile_id,
	input logic has_explosion,
	input bomberman_pkg::coord_t p1_x,
	input bomberman_pkg::coord_t p1_y,
	input bomberman_pkg::coord_t p2_x,
	input bomberman_pkg::coord_t p2_y,
	output bomberman_pkg::coord_t probe_x,
	output bomberman_pkg::coord_t probe_y,
	output logic destroy_tile,
	tile_check_if.decode p1_chk,
	tile_check_if.decode p2_chk
);

	bomberman_pkg::coord_t base_x;
	bomberman_pkg::coord_t base_y;
	bomberman_pkg::pickup_t pickup;
	logic passable;
	logic removable;
	logic any_check;

	assign any_check = check_p1 | check_p2;
	assign base_x = check_p1 ? p1_x : p2_x;	// p1 wins when both check.
	assign base_y = check_p1 ? p1_y : p2_y;
	assign probe_x = base_x + (corner_id[0] ? bomberman_pkg::SPRITE_SPAN : 9'd0);
	assign probe_y = base_y + (corner_id[1] ? bomberman_pkg::SPRITE_SPAN : 9'd0);

	always_comb
	begin
		passable = 1'b1;
		removable = 1'b0;
		pickup = bomberman_pkg::pick_none;
		case (map_tile_id)
			bomberman_pkg::tile_empty, bomberman_pkg::tile_p1, bomberman_pkg::tile_p2,
			bomberman_pkg::tile_p1_inv, bomberman_pkg::tile_p2_inv:
				passable = 1'b1;
			bomberman_pkg::tile_pow_bomb:
			begin
				removable = 1'b1;
				pickup = bomberman_pkg::pick_bomb;
			end
			bomberman_pkg::tile_pow_radius:
			begin
				removable = 1'b1;
				pickup = bomberman_pkg::pick_radius;
			end
			bomberman_pkg::tile_pow_potency:
			begin
				removable = 1'b1;
				pickup = bomberman_pkg::pick_potency;
			end
			bomberman_pkg::tile_pow_throw:
				removable = 1'b1;	// taken off the stage, no stat change.
			bomberman_pkg::tile_pow_life:
			begin
				removable = 1'b1;
				pickup = bomberman_pkg::pick_life;
			end
			bomberman_pkg::tile_pow_speed:
			begin
				removable = 1'b1;
				pickup = bomberman_pkg::pick_speed;
			end
			default:
				passable = 1'b0;	// walls, bricks, unused ids.
		endcase
	end

	assign p1_chk.check = check_p1;
	assign p2_chk.check = check_p2 & ~check_p1;	// probe belongs to p1 then.
	assign p1_chk.corner = corner_id;
	assign p2_chk.corner = corner_id;
	assign p1_chk.passable = passable;
	assign p2_chk.passable = passable;
	assign p1_chk.pickup = pickup;
	assign p2_chk.pickup = pickup;
	assign p1_chk.hit = has_explosion;
	assign p2_chk.hit = has_explosion;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			destroy_tile <= 1'b0;
		else if (game_reset)
			destroy_tile <= 1'b0;
		else
			destroy_tile <= any_check & removable;	// one pulse after a pickup check.
	end

endmodule

// ==== logic/tile_check_if.sv ====
// one player's decoded tile check, driven by the tile decoder and read by stats and motion.
`timescale 1ns/1ns

interface tile_check_if;

	logic check;						// this player is being checked now.
	logic [1:0] corner;					// bit 0 right, bit 1 down.
	logic passable;
	bomberman_pkg::pickup_t pickup;
	logic hit;							// explosion on the probed tile.

	modport decode (
		output check, corner, passable, pickup, hit
	);

	modport player (
		input check, corner, passable, pickup, hit
	);

endinterface

// ==== logic/bomberman_pkg.sv ====
// shared types, tile encodings and game limits; referenced by scoped name from every design file.
package bomberman_pkg;

	typedef logic [8:0] coord_t;	// screen pixel coordinate.
	typedef logic [3:0] speed_t;	// pixels per refresh.
	typedef logic [1:0] lives_t;
	typedef logic [1:0] stat_t;		// one power stat.

	// stage tile ids as stored in the stage memory.
	typedef enum logic [3:0] {
		tile_empty       = 4'd0,
		tile_wall        = 4'd1,
		tile_brick       = 4'd2,
		tile_pow_bomb    = 4'd3,
		tile_pow_radius  = 4'd4,
		tile_pow_potency = 4'd5,
		tile_pow_throw   = 4'd6,
		tile_pow_life    = 4'd7,
		tile_pow_speed   = 4'd8,
		tile_p1          = 4'd12,
		tile_p2          = 4'd13,
		tile_p1_inv      = 4'd14,
		tile_p2_inv      = 4'd15
	} tile_id_t;

	// pickup kind handed from the decoder to the stats block.
	typedef enum logic [2:0] {
		pick_none,
		pick_bomb,
		pick_radius,
		pick_potency,
		pick_life,
		pick_speed
	} pickup_t;

	// arena bounds for the sprite's top left corner.
	localparam coord_t X_MIN = 9'd72;
	localparam coord_t X_MAX = 9'd232;
	localparam coord_t Y_MIN = 9'd32;
	localparam coord_t Y_MAX = 9'd192;

	localparam coord_t P1_START_X = 9'd72;
	localparam coord_t P2_START_X = 9'd232;
	localparam coord_t START_Y    = 9'd112;

	// offset from top left to the far corners of a 16 pixel sprite.
	localparam coord_t SPRITE_SPAN = 9'd15;

	localparam lives_t START_LIVES = 2'd3;
	localparam lives_t LIFE_LIMIT  = 2'd3;

	localparam speed_t START_SPEED = 4'd4;
	localparam speed_t SPEED_LIMIT = 4'd8;

	localparam stat_t STAT_LIMIT = 2'd2;	// bombs, radius and potency.

endpackage
